// ==== rtl/mips_isa_pkg.sv ====
// mips32 encodings for the supported integer subset; other opcodes and functs decode as nop
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // special function codes
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    // field bounds inside the word
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RS_HI     = 25;
    localparam int RS_LO     = 21;
    localparam int RT_HI     = 20;
    localparam int RT_LO     = 16;
    localparam int RD_HI     = 15;
    localparam int RD_LO     = 11;
    localparam int IMM_HI    = 15;
    localparam int IMM_LO    = 0;
    localparam int FUNCT_HI  = 5;
    localparam int FUNCT_LO  = 0;

endpackage

`default_nettype wire

// ==== rtl/mips_core_pkg.sv ====
// pipeline types for the core; the all-zero word is the nop that bubbles carry
`default_nettype none

package mips_core_pkg;

    typedef logic [31:0] word_t;     // data word or byte address
    typedef logic [4:0]  reg_addr_t;

    localparam int NUM_REGS = 32;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // bubble contents
    localparam word_t   NOP_WORD   = '0;
    localparam alu_op_e NOP_ALU_OP = ALU_OR;
    localparam mem_op_e NOP_MEM_OP = MEM_NONE;

endpackage

`default_nettype wire

// ==== rtl/fwd_if.sv ====
// pending register write of one stage, seen by decode in the same cycle
`timescale 1ns/1ps
`default_nettype none

interface fwd_if import mips_core_pkg::*; ();

    logic      wreg;
    reg_addr_t wd;
    word_t     wdata;
    logic      is_load;  // wdata not yet valid in execute

    modport src (
        output wreg, wd, wdata, is_load
    );

    modport snk (
        input wreg, wd, wdata, is_load
    );

endinterface

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// rom must return the word for rom_addr_o in the same cycle; no branches, pc only counts up
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_core_pkg::*, mips_isa_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  stall_i,
    input  inst_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output inst_t id_inst_o
);

    word_t pc;
    logic  ce;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= RESET_PC;
            ce <= 1'b0;
        end else begin
            ce <= 1'b1;
            if (ce && !stall_i) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // fetch/decode register, holds on load-use
    always_ff @(posedge clk_i) begin
        if (rst_i || !ce) begin
            id_inst_o <= NOP_WORD;
        end else if (!stall_i) begin
            id_inst_o <= rom_data_i;
        end
    end

    assign rom_addr_o = pc;
    assign rom_ce_o   = ce;

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// r0 reads zero and ignores writes; a same-cycle write is bypassed to both read ports
`timescale 1ns/1ps
`default_nettype none

module regfile import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic word_t read_port(reg_addr_t a);
        if (a == '0) return '0;
        if (we_i && waddr_i == a) return wdata_i;  // write-through
        return regs[a];
    endfunction

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// unknown opcodes become nops; a load in execute feeding this instruction costs one bubble
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_core_pkg::*, mips_isa_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  inst_t     inst_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    fwd_if.snk        ex_fwd,
    fwd_if.snk        mem_fwd,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    output logic      stall_o,
    output alu_op_e   alu_op_o,
    output word_t     opnd_a_o,
    output word_t     opnd_b_o,
    output word_t     store_data_o,
    output mem_op_e   mem_op_o,
    output reg_addr_t wd_o,
    output logic      wreg_o
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm_sext;
    word_t     imm_zext;
    word_t     rs_val;
    word_t     rt_val;
    alu_op_e   dec_alu;
    mem_op_e   dec_mem;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    logic      use_rs;
    logic      use_rt;
    logic      imm_sel;
    logic      zext_sel;
    logic      load_use;

    assign opcode   = inst_i[OPCODE_HI:OPCODE_LO];
    assign funct    = inst_i[FUNCT_HI:FUNCT_LO];
    assign rs       = inst_i[RS_HI:RS_LO];
    assign rt       = inst_i[RT_HI:RT_LO];
    assign rd       = inst_i[RD_HI:RD_LO];
    assign imm_sext = {{16{inst_i[IMM_HI]}}, inst_i[IMM_HI:IMM_LO]};
    assign imm_zext = {16'h0000, inst_i[IMM_HI:IMM_LO]};

    always_comb begin
        dec_alu  = NOP_ALU_OP;
        dec_mem  = NOP_MEM_OP;
        dec_wd   = rt;
        dec_wreg = 1'b0;
        use_rs   = 1'b1;
        use_rt   = 1'b0;
        imm_sel  = 1'b1;
        zext_sel = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dec_wd   = rd;
                dec_wreg = 1'b1;
                use_rt   = 1'b1;
                imm_sel  = 1'b0;
                case (funct)
                    FN_ADDU: dec_alu = ALU_ADD;
                    FN_SUBU: dec_alu = ALU_SUB;
                    FN_AND:  dec_alu = ALU_AND;
                    FN_OR:   dec_alu = ALU_OR;
                    FN_XOR:  dec_alu = ALU_XOR;
                    FN_SLT:  dec_alu = ALU_SLT;
                    default: begin  // sll 0,0,0 lands here
                        dec_wreg = 1'b0;
                        use_rs   = 1'b0;
                        use_rt   = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                dec_alu  = ALU_ADD;
                dec_wreg = 1'b1;
            end
            OP_SLTI: begin
                dec_alu  = ALU_SLT;
                dec_wreg = 1'b1;
            end
            OP_ANDI: begin
                dec_alu  = ALU_AND;
                dec_wreg = 1'b1;
                zext_sel = 1'b1;
            end
            OP_ORI: begin
                dec_alu  = ALU_OR;
                dec_wreg = 1'b1;
                zext_sel = 1'b1;
            end
            OP_XORI: begin
                dec_alu  = ALU_XOR;
                dec_wreg = 1'b1;
                zext_sel = 1'b1;
            end
            OP_LUI: begin
                dec_alu  = ALU_LUI;
                dec_wreg = 1'b1;
                use_rs   = 1'b0;
                zext_sel = 1'b1;
            end
            OP_LW: begin
                dec_alu  = ALU_ADD;
                dec_mem  = MEM_LOAD;
                dec_wreg = 1'b1;
            end
            OP_SW: begin
                dec_alu = ALU_ADD;
                dec_mem = MEM_STORE;
                use_rt  = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    // execute beats memory beats the register file
    function automatic word_t fwd_val(reg_addr_t r, word_t rf_val);
        if (r != '0 && ex_fwd.wreg && ex_fwd.wd == r) return ex_fwd.wdata;
        if (r != '0 && mem_fwd.wreg && mem_fwd.wd == r) return mem_fwd.wdata;
        return rf_val;
    endfunction

    assign rs_val = fwd_val(rs, rdata1_i);
    assign rt_val = fwd_val(rt, rdata2_i);

    assign load_use = ex_fwd.is_load && ex_fwd.wreg && ex_fwd.wd != '0 &&
                      ((use_rs && ex_fwd.wd == rs) || (use_rt && ex_fwd.wd == rt));

    always_ff @(posedge clk_i) begin
        if (rst_i || load_use) begin
            alu_op_o <= NOP_ALU_OP;
            mem_op_o <= NOP_MEM_OP;
            wreg_o   <= 1'b0;
        end else begin
            alu_op_o <= dec_alu;
            mem_op_o <= dec_mem;
            wreg_o   <= dec_wreg;
        end
    end

    always_ff @(posedge clk_i) begin
        opnd_a_o     <= rs_val;
        opnd_b_o     <= imm_sel ? (zext_sel ? imm_zext : imm_sext) : rt_val;
        store_data_o <= rt_val;  // sw data
        wd_o         <= dec_wd;
    end

    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign stall_o  = load_use;

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// single-cycle alu; load and store addresses come from the same adder as addu
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  alu_op_e   alu_op_i,
    input  word_t     opnd_a_i,
    input  word_t     opnd_b_i,
    input  word_t     store_data_i,
    input  mem_op_e   mem_op_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    fwd_if.src        ex_fwd,
    output mem_op_e   mem_op_o,
    output word_t     addr_o,
    output word_t     store_data_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output word_t     result_o
);

    word_t sum;
    word_t alu_res;

    assign sum = opnd_a_i + opnd_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: alu_res = sum;
            ALU_SUB: alu_res = opnd_a_i - opnd_b_i;
            ALU_AND: alu_res = opnd_a_i & opnd_b_i;
            ALU_OR:  alu_res = opnd_a_i | opnd_b_i;
            ALU_XOR: alu_res = opnd_a_i ^ opnd_b_i;
            ALU_SLT: alu_res = {31'b0, $signed(opnd_a_i) < $signed(opnd_b_i)};
            ALU_LUI: alu_res = {opnd_b_i[15:0], 16'h0000};
            default: alu_res = sum;
        endcase
    end

    assign ex_fwd.wreg    = wreg_i;
    assign ex_fwd.wd      = wd_i;
    assign ex_fwd.wdata   = alu_res;  // only an address for lw
    assign ex_fwd.is_load = (mem_op_i == MEM_LOAD);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_op_o <= NOP_MEM_OP;
            wreg_o   <= 1'b0;
        end else begin
            mem_op_o <= mem_op_i;
            wreg_o   <= wreg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_o       <= sum;
        store_data_o <= store_data_i;
        wd_o         <= wd_i;
        result_o     <= alu_res;
    end

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
// word accesses only; ram_data_i must be valid in the same cycle as a lw request
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  mem_op_e   mem_op_i,
    input  word_t     addr_i,
    input  word_t     store_data_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    input  word_t     result_i,
    input  word_t     ram_data_i,
    output word_t     ram_addr_o,
    output word_t     ram_data_o,
    output logic      ram_we_o,
    output logic      ram_ce_o,
    fwd_if.src        mem_fwd,
    output logic      wb_we_o,
    output reg_addr_t wb_waddr_o,
    output word_t     wb_wdata_o
);

    word_t wdata;
    logic  is_load;

    assign is_load    = (mem_op_i == MEM_LOAD);
    assign wdata      = is_load ? ram_data_i : result_i;
    assign ram_addr_o = addr_i;
    assign ram_data_o = store_data_i;
    assign ram_we_o   = (mem_op_i == MEM_STORE);
    assign ram_ce_o   = (mem_op_i != MEM_NONE);

    assign mem_fwd.wreg    = wreg_i;
    assign mem_fwd.wd      = wd_i;
    assign mem_fwd.wdata   = wdata;
    assign mem_fwd.is_load = is_load;

    always_ff @(posedge clk_i) begin
        if (rst_i) wb_we_o <= 1'b0;
        else       wb_we_o <= wreg_i;
    end

    always_ff @(posedge clk_i) begin
        wb_waddr_o <= wd_i;
        wb_wdata_o <= wdata;
    end

endmodule

`default_nettype wire

// ==== rtl/openmips.sv ====
// five-stage core, no branches; rom and ram must both answer in the same cycle
`timescale 1ns/1ps
`default_nettype none

module openmips import mips_core_pkg::*, mips_isa_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  inst_t rom_data_i,
    input  word_t ram_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t ram_addr_o,
    output word_t ram_data_o,
    output logic  ram_we_o,
    output logic  ram_ce_o
);

    logic      stall;
    inst_t     id_inst;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    // decode to execute
    alu_op_e   id_alu_op;
    word_t     id_opnd_a;
    word_t     id_opnd_b;
    word_t     id_store_data;
    mem_op_e   id_mem_op;
    reg_addr_t id_wd;
    logic      id_wreg;
    // execute to memory
    mem_op_e   ex_mem_op;
    word_t     ex_addr;
    word_t     ex_store_data;
    reg_addr_t ex_wd;
    logic      ex_wreg;
    word_t     ex_result;
    // write-back
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .id_inst_o  (id_inst)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (wb_we),
        .waddr_i  (wb_waddr),
        .wdata_i  (wb_wdata),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    decode_stage u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_i       (id_inst),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd       (ex_fwd),
        .mem_fwd      (mem_fwd),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .stall_o      (stall),
        .alu_op_o     (id_alu_op),
        .opnd_a_o     (id_opnd_a),
        .opnd_b_o     (id_opnd_b),
        .store_data_o (id_store_data),
        .mem_op_o     (id_mem_op),
        .wd_o         (id_wd),
        .wreg_o       (id_wreg)
    );

    execute_stage u_execute (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .alu_op_i     (id_alu_op),
        .opnd_a_i     (id_opnd_a),
        .opnd_b_i     (id_opnd_b),
        .store_data_i (id_store_data),
        .mem_op_i     (id_mem_op),
        .wd_i         (id_wd),
        .wreg_i       (id_wreg),
        .ex_fwd       (ex_fwd),
        .mem_op_o     (ex_mem_op),
        .addr_o       (ex_addr),
        .store_data_o (ex_store_data),
        .wd_o         (ex_wd),
        .wreg_o       (ex_wreg),
        .result_o     (ex_result)
    );

    memory_stage u_memory (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_op_i     (ex_mem_op),
        .addr_i       (ex_addr),
        .store_data_i (ex_store_data),
        .wd_i         (ex_wd),
        .wreg_i       (ex_wreg),
        .result_i     (ex_result),
        .ram_data_i   (ram_data_i),
        .ram_addr_o   (ram_addr_o),
        .ram_data_o   (ram_data_o),
        .ram_we_o     (ram_we_o),
        .ram_ce_o     (ram_ce_o),
        .mem_fwd      (mem_fwd),
        .wb_we_o      (wb_we),
        .wb_waddr_o   (wb_waddr),
        .wb_wdata_o   (wb_wdata)
    );

endmodule

`default_nettype wire

// ==== dv/tb_ref_model.svh ====
// in-order architectural model over the tb's prog and ref_ram arrays; word accesses, 256-word ram

function automatic inst_t enc_r(funct_t fn, int rd, int rs, int rt);
    return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic inst_t enc_i(opcode_t op, int rt, int rs, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// runs len instructions and queues the expected stores
function automatic void ref_run(int len);
    word_t   r [NUM_REGS];
    inst_t   ins;
    word_t   a;
    word_t   b;
    word_t   sx;
    word_t   zx;
    word_t   v;
    logic    wr;
    int      dst;
    for (int i = 0; i < NUM_REGS; i++) r[i] = '0;
    for (int i = 0; i < len; i++) begin
        ins = prog[i];
        a   = r[ins[25:21]];
        b   = r[ins[20:16]];
        sx  = {{16{ins[15]}}, ins[15:0]};
        zx  = {16'h0000, ins[15:0]};
        wr  = 1'b1;
        dst = ins[20:16];
        v   = '0;
        case (ins[31:26])
            OP_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: v = a + b;
                    FN_SUBU: v = a - b;
                    FN_AND:  v = a & b;
                    FN_OR:   v = a | b;
                    FN_XOR:  v = a ^ b;
                    FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: v = a + sx;
            OP_SLTI:  v = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI:  v = a & zx;
            OP_ORI:   v = a | zx;
            OP_XORI:  v = a ^ zx;
            OP_LUI:   v = {ins[15:0], 16'h0000};
            OP_LW:    v = ref_ram[(a + sx) >> 2 & 32'hff];
            OP_SW: begin
                wr = 1'b0;
                exp_addr_q.push_back(a + sx);
                exp_data_q.push_back(b);
                ref_ram[(a + sx) >> 2 & 32'hff] = b;
            end
            default:  wr = 1'b0;  // unknown is a nop
        endcase
        if (wr && dst != 0) r[dst] = v;
    end
endfunction

// ==== dv/tb_openmips.sv ====
// self-checking tb for openmips; rom and ram hold 256 words each, RESET_PC is zero
`timescale 1ns/1ps
`default_nettype none

module tb_openmips import mips_core_pkg::*, mips_isa_pkg::*;;

    localparam word_t RESET_PC = '0;
    localparam inst_t NOP      = '0;

    logic  clk_i;
    logic  rst_i;
    inst_t rom_data_i;
    word_t ram_data_i;
    word_t rom_addr_o;
    logic  rom_ce_o;
    word_t ram_addr_o;
    word_t ram_data_o;
    logic  ram_we_o;
    logic  ram_ce_o;

    inst_t  rom [256];
    word_t  ram [256];
    inst_t  prog [256];
    word_t  ref_ram [256];
    int     plen;
    word_t  exp_addr_q [$];
    word_t  exp_data_q [$];
    word_t  fetch_q [$];
    string  cur_name;
    logic   active;
    logic   rst_q;
    int     errors;
    int     tests;
    int     failed_tests;
    int     cycles;
    int     limit;
    integer seed;

    `include "tb_ref_model.svh"

    openmips #(.RESET_PC(RESET_PC)) u_openmips (
        .clk_i(clk_i), .rst_i(rst_i), .rom_data_i(rom_data_i), .ram_data_i(ram_data_i),
        .rom_addr_o(rom_addr_o), .rom_ce_o(rom_ce_o), .ram_addr_o(ram_addr_o),
        .ram_data_o(ram_data_o), .ram_we_o(ram_we_o), .ram_ce_o(ram_ce_o)
    );

    assign rom_data_i = rom[rom_addr_o[9:2]];
    assign ram_data_i = ram[ram_addr_o[9:2]];  // same-cycle read

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_store_addr(word_t exp, word_t act);
        if (exp !== act) begin
            $display("FAILED %s store addr expected %h actual %h", cur_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_store_data(word_t exp, word_t act);
        if (exp !== act) begin
            $display("FAILED %s store data expected %h actual %h", cur_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_fetch_addr(word_t exp, word_t act);
        if (exp !== act) begin
            $display("FAILED %s fetch addr expected %h actual %h", cur_name, exp, act);
            errors++;
        end
    endtask

    // compares each store against the reference stream as it happens
    always @(posedge clk_i) begin
        if (rst_q && (rom_ce_o || ram_ce_o || ram_we_o)) begin
            $display("%s: a memory enable was high during reset", cur_name);
            errors++;
        end
        rst_q <= rst_i;  // enables drop one edge after reset is seen
        if (active && rom_ce_o) fetch_q.push_back(rom_addr_o);
        if (active && ram_ce_o && ram_we_o) begin
            ram[ram_addr_o[9:2]] <= ram_data_o;
            if (exp_addr_q.size() == 0) begin
                $display("%s: extra store to %h not in the reference", cur_name, ram_addr_o);
                errors++;
            end else begin
                check_store_addr(exp_addr_q.pop_front(), ram_addr_o);
                check_store_data(exp_data_q.pop_front(), ram_data_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout in %s after %0d cycles, pipeline never drained", cur_name, cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic emit(inst_t i);
        prog[plen] = i;
        plen++;
    endtask

    task automatic emit_gap(inst_t i);  // three nops keep it independent
        emit(i);
        repeat (3) emit(NOP);
    endtask

    task automatic check_fetch(int len, int exp_repeats);
        int rep;
        rep = 0;
        check_fetch_addr(RESET_PC, fetch_q[0]);
        for (int i = 1; i < fetch_q.size() && fetch_q[i] < RESET_PC + len * 4; i++) begin
            if (fetch_q[i] == fetch_q[i-1]) rep++;
            else check_fetch_addr(RESET_PC + 4 * (i - rep), fetch_q[i]);
        end
        if (rep != exp_repeats) begin
            $display("%s: fetch address repeated %0d times, wanted %0d", cur_name, rep,
                     exp_repeats);
            errors++;
        end
    endtask

    // exp_repeats below zero skips the fetch order check
    task automatic run_test(string name, int exp_repeats);
        int    err0;
        int    len;
        word_t end_addr;
        repeat (6) emit(NOP);  // drain
        len      = plen;
        cur_name = name;
        err0     = errors;
        for (int i = 0; i < 256; i++) begin
            rom[i]     = (i < len) ? prog[i] : NOP;
            ram[i]     = 32'h5a00_0000 ^ (i * 32'h0001_0203);
            ref_ram[i] = ram[i];
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        fetch_q.delete();
        ref_run(len);
        limit += 2 * len + 20;
        rst_i = 1'b1;
        repeat (8) @(posedge clk_i);
        #1 rst_i = 1'b0;
        active = 1'b1;
        end_addr = RESET_PC + len * 4;
        while (!(rom_ce_o && rom_addr_o >= end_addr)) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1 active = 1'b0;
        if (exp_addr_q.size() != 0) begin
            $display("%s: %0d expected stores never happened", name, exp_addr_q.size());
            errors++;
        end
        if (exp_repeats >= 0) check_fetch(len, exp_repeats);
        tests++;
        if (errors != err0) failed_tests++;
        $display("test %s: %s", name, (errors == err0) ? "ok" : "mismatch");
        plen = 0;
    endtask

    initial begin
        int k;
        int ra;
        int rb;
        int rc;
        funct_t  fns [6];
        opcode_t ops [6];
        fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
        ops = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        rst_i = 1'b1;
        rst_q = 1'b0;
        active = 1'b0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        cycles = 0;
        limit = 0;
        plen = 0;
        seed = 32'h8e30_5165;
        cur_name = "reset";

        emit(enc_i(OP_ADDIU, 1, 0, 5));
        emit(enc_i(OP_ORI, 2, 0, 3));
        repeat (3) emit(NOP);
        emit(enc_i(OP_SW, 1, 0, 0));
        emit(enc_i(OP_SW, 2, 0, 4));
        run_test("reset_fetch", 0);

        emit_gap(enc_i(OP_ADDIU, 1, 0, 16'h1234));
        emit_gap(enc_i(OP_ADDIU, 2, 0, 16'hfff9));
        for (int i = 0; i < 6; i++) begin
            emit_gap(enc_r(fns[i], 3 + i, 1, 2));
            emit_gap(enc_i(OP_SW, 3 + i, 0, 4 * i));
        end
        for (int i = 0; i < 6; i++) begin
            emit_gap(enc_i(ops[i], 10 + i, 2, 16'h8a5c));
            emit_gap(enc_i(OP_SW, 10 + i, 0, 32 + 4 * i));
        end
        emit_gap(enc_i(OP_ADDIU, 0, 1, 5));  // r0 stays zero
        emit_gap(enc_r(FN_ADDU, 0, 1, 2));
        emit_gap(enc_i(OP_SW, 0, 0, 64));
        run_test("alu_ops", 0);

        emit(enc_i(OP_ADDIU, 1, 0, 7));
        emit(enc_r(FN_ADDU, 2, 1, 1));
        emit(enc_i(OP_XORI, 3, 1, 16'h00f0));
        emit(enc_r(FN_SUBU, 4, 2, 1));
        emit(enc_r(FN_OR, 5, 2, 4));
        emit(enc_r(FN_SLT, 6, 3, 5));
        emit(enc_i(OP_SW, 5, 0, 0));
        emit(enc_i(OP_SW, 4, 0, 4));
        emit(enc_i(OP_SW, 6, 0, 8));
        emit(enc_i(OP_SW, 3, 0, 12));
        emit(enc_r(FN_ADDU, 0, 1, 1));  // r0 writes in memory and execute, never forwarded
        emit(enc_i(OP_ADDIU, 0, 1, 9));
        emit(enc_i(OP_SW, 0, 0, 16));
        run_test("forwarding", 0);

        emit_gap(enc_i(OP_LUI, 1, 0, 16'hdead));
        emit(enc_i(OP_SW, 1, 0, 8));
        emit(enc_i(OP_LW, 2, 0, 8));
        emit(enc_r(FN_ADDU, 3, 2, 2));
        emit(enc_i(OP_SW, 3, 0, 12));
        emit(enc_i(OP_SW, 2, 0, 16));
        run_test("load_use", 1);

        for (int i = 0; i < 80; i++) begin
            k  = {$random(seed)} % 10;
            ra = 1 + {$random(seed)} % 7;
            rb = 1 + {$random(seed)} % 7;
            rc = 1 + {$random(seed)} % 7;
            if (k < 6) emit(enc_r(fns[k], ra, rb, rc));
            else if (k < 8) emit(enc_i(ops[{$random(seed)} % 6], ra, rb, $random(seed)));
            else if (k == 8) emit(enc_i(OP_LW, ra, 0, 4 * ({$random(seed)} % 16)));
            else emit(enc_i(OP_SW, ra, 0, 4 * ({$random(seed)} % 16)));
        end
        for (int i = 1; i < 8; i++) emit(enc_i(OP_SW, i, 0, 128 + 4 * i));
        run_test("random_mix", -1);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/mips_isa_pkg.sv
rtl/mips_core_pkg.sv
rtl/fwd_if.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/openmips.sv
+incdir+dv
dv/tb_openmips.sv

// ==== run.sh ====
#!/bin/sh
# builds with verilator, runs the testbench, and fails if the log reports a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_openmips -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
